//--- hw/siFh_settings.svh
`ifndef SIFH_SETTINGS_SVH
`define SIFH_SETTINGS_SVH

// bin index width
`define NB 4

// threshold level width
// one bin spans 2**(NP-NB) levels
`define NP 8

// width of a single histogram bin count
`define COUNT_W 12

// bins per pixel histogram
`define BIN_NUM 16

// pixels held in the threshold store
`define PIXEL_NUM_PER_RAM 16

// pixel index width, must cover PIXEL_NUM_PER_RAM
`define PIXEL_IDX_W 4

// noise floor
// peaks below this count are flagged invalid
`define MIN_PEAK_COUNT 8

`endif

//--- hw/siFhPkg.sv
`include "siFh_settings.svh"

package siFhPkg;

    // bin index inside one pixel histogram
    typedef logic [`NB - 1 : 0] binIdxT;

    // threshold level, finer grid than bins
    typedef logic [`NP - 1 : 0] levelT;

    // photon count of one bin
    typedef logic [`COUNT_W - 1 : 0] countT;

    // pixel address
    typedef logic [`PIXEL_IDX_W - 1 : 0] pixelIdxT;

    // peak of one pixel, handed from peakFinder to algebraicBlock
    typedef struct packed {
        pixelIdxT pixelIdx;
        // bin holding the highest count
        binIdxT   peakCh;
        // count found in that bin
        countT    peakCount;
    } peakT;

    // per-pixel result as stored in thresholdRam
    typedef struct packed {
        // lower edge of the window
        levelT    thMinus;
        // upper edge of the window
        levelT    thPositive;
        countT    peakCount;
        // peak above noise floor
        logic     peakValid;
    } thRecordT;

endpackage

//--- hw/peakFinder.sv
`timescale 1ns/100ps
`include "siFh_settings.svh"

module peakFinder
    import siFhPkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    // one strobe per histogram bin
    input  logic  binValid,
    input  countT binCount,
    // one strobe per pixel, cycle after its last bin
    output logic  peakDone,
    output peakT  peak
);

    // position inside the incoming stream
    binIdxT   binCnt;
    pixelIdxT pixelCnt;

    // running maximum of the current pixel
    countT    runMax;
    binIdxT   runIdx;

    // maximum including the bin on the bus
    countT    nextMax;
    binIdxT   nextIdx;

    logic     lastBin;
    logic     lastPixel;

    assign lastBin   = (binCnt == binIdxT'(`BIN_NUM - 1));
    assign lastPixel = (pixelCnt == pixelIdxT'(`PIXEL_NUM_PER_RAM - 1));

    // compare against running max
    // strict greater keeps the lowest bin on ties
    always_comb begin
        nextMax = runMax;
        nextIdx = runIdx;
        if (binCnt == '0) begin
            // first bin of a pixel, restart the search
            nextMax = binCount;
            nextIdx = '0;
        end else if (binCount > runMax) begin
            nextMax = binCount;
            nextIdx = binCnt;
        end
    end

    // bin and pixel counters
    always_ff @(posedge clk) begin
        if (!rstN) begin
            binCnt   <= '0;
            pixelCnt <= '0;
        end else if (binValid) begin
            if (lastBin) begin
                binCnt <= '0;
                // wrap after the last pixel of the store
                if (lastPixel) begin
                    pixelCnt <= '0;
                end else begin
                    pixelCnt <= pixelCnt + pixelIdxT'(1);
                end
            end else begin
                binCnt <= binCnt + binIdxT'(1);
            end
        end
    end

    // running max only moves on a strobe
    always_ff @(posedge clk) begin
        if (binValid) begin
            runMax <= nextMax;
            runIdx <= nextIdx;
        end
    end

    // completion strobe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakDone <= 1'b0;
        end else begin
            peakDone <= binValid && lastBin;
        end
    end

    // peak record, captured on the last bin
    always_ff @(posedge clk) begin
        if (binValid && lastBin) begin
            peak.pixelIdx  <= pixelCnt;
            peak.peakCh    <= nextIdx;
            peak.peakCount <= nextMax;
        end
    end

endmodule

//--- hw/algebraicBlock.sv
`timescale 1ns/100ps
`include "siFh_settings.svh"

module algebraicBlock
    import siFhPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    // peak of one pixel
    input  logic     peakDone,
    input  peakT     peak,
    // registered window, one cycle after peakDone
    output logic     algebraicReady,
    output pixelIdxT thPixel,
    output thRecordT thRecord
);

    // bin to level conversion
    localparam int unsigned LevelShift = `NP - `NB;

    // side band, one bin width in levels
    localparam levelT SideBand = levelT'(1) << LevelShift;

    // full window width
    localparam levelT TwoSideBand = levelT'(SideBand << 1);

    // top of the level range
    localparam levelT LevelMax = '1;

    // peak channel in level units
    levelT    chLevel;

    // combinational result before the register
    thRecordT nextRecord;

    always_comb begin
        chLevel = levelT'(peak.peakCh) << LevelShift;

        // defaults for the centred window
        nextRecord.thMinus    = chLevel - SideBand;
        nextRecord.thPositive = chLevel + SideBand;

        if (chLevel < SideBand) begin
            // window would drop below zero, pin to bottom
            nextRecord.thMinus    = '0;
            nextRecord.thPositive = TwoSideBand;
        end else if (chLevel > (LevelMax - SideBand)) begin
            // window would overflow, pin to top
            nextRecord.thMinus    = LevelMax - TwoSideBand;
            nextRecord.thPositive = LevelMax;
        end

        // count passes through
        nextRecord.peakCount = peak.peakCount;

        // noise floor check, window still filled in
        nextRecord.peakValid = (peak.peakCount >= countT'(`MIN_PEAK_COUNT));
    end

    // strobe follows peakDone by one cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            algebraicReady <= 1'b0;
        end else begin
            algebraicReady <= peakDone;
        end
    end

    // result payload
    // held between strobes
    always_ff @(posedge clk) begin
        if (peakDone) begin
            thPixel  <= peak.pixelIdx;
            thRecord <= nextRecord;
        end
    end

endmodule

//--- hw/thresholdRam.sv
`timescale 1ns/100ps
`include "siFh_settings.svh"

module thresholdRam
    import siFhPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    // write side, from algebraicBlock
    input  logic     algebraicReady,
    input  pixelIdxT thPixel,
    input  thRecordT thRecord,
    // read side, one cycle latency
    input  pixelIdxT rdAddr,
    output thRecordT rdData
);

    // one record per pixel
    thRecordT mem [`PIXEL_NUM_PER_RAM];

    // write port
    // reset walks every entry to zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `PIXEL_NUM_PER_RAM; i++) begin
                mem[i] <= '0;
            end
        end else if (algebraicReady) begin
            mem[thPixel] <= thRecord;
        end
    end

    // read port
    // same-edge write is not visible yet, so old data comes back
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdData <= '0;
        end else begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

//--- hw/siFhTop.sv
`timescale 1ns/100ps

module siFhTop
    import siFhPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    // histogram bin stream
    input  logic     binValid,
    input  countT    binCount,
    // readback address into the record store
    input  pixelIdxT rdAddr,
    // completion strobe and its pixel
    output logic     algebraicReady,
    output pixelIdxT thPixel,
    output thRecordT rdData
);

    // peakFinder to algebraicBlock
    logic     peakDone;
    peakT     peak;

    // algebraicBlock to thresholdRam
    thRecordT thRecord;

    // per-pixel maximum search
    peakFinder peakFinder_i (
        .clk      (clk),
        .rstN     (rstN),
        .binValid (binValid),
        .binCount (binCount),
        .peakDone (peakDone),
        .peak     (peak)
    );

    // threshold window around the peak
    algebraicBlock algebraicBlock_i (
        .clk            (clk),
        .rstN           (rstN),
        .peakDone       (peakDone),
        .peak           (peak),
        .algebraicReady (algebraicReady),
        .thPixel        (thPixel),
        .thRecord       (thRecord)
    );

    // result store, read from outside
    thresholdRam thresholdRam_i (
        .clk            (clk),
        .rstN           (rstN),
        .algebraicReady (algebraicReady),
        .thPixel        (thPixel),
        .thRecord       (thRecord),
        .rdAddr         (rdAddr),
        .rdData         (rdData)
    );

endmodule

//--- tb/clockGen.sv
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic rstN
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // synchronous reset, low for the first 16 edges
    initial begin
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

//--- tb/siFhTop_assert.sv
`timescale 1ns/100ps

module siFhTop_assert
    import siFhPkg::*;
(
    input logic     clk,
    input logic     rstN,
    input logic     peakDone,
    input logic     algebraicReady,
    input thRecordT thRecord
);

    // number of failed assertions, read by the testbench at the end of the run
    int failCount = 0;

    // completion strobe is one register stage behind peakDone
    readyAfterPeak: assert property (@(posedge clk) disable iff (!rstN)
        peakDone |=> algebraicReady)
    else begin
        failCount++;
        $error("algebraicReady did not follow peakDone");
    end

    // and never shows up without a peak before it
    readyOnlyAfterPeak: assert property (@(posedge clk) disable iff (!rstN)
        algebraicReady |-> $past(peakDone))
    else begin
        failCount++;
        $error("algebraicReady without a peakDone one cycle earlier");
    end

    // window edges in order whenever a record is handed over
    windowOrdered: assert property (@(posedge clk) disable iff (!rstN)
        algebraicReady |-> (thRecord.thMinus <= thRecord.thPositive))
    else begin
        failCount++;
        $error("thMinus above thPositive");
    end

    // reset clears the peak strobe
    peakLowInReset: assert property (@(posedge clk)
        !rstN |=> !peakDone)
    else begin
        failCount++;
        $error("peakDone high during reset");
    end

endmodule

//--- tb/siFhTb.sv
`timescale 1ns/100ps
`include "siFh_settings.svh"

module siFhTb
    import siFhPkg::*;
();

    localparam int Rows         = `PIXEL_NUM_PER_RAM + 2;
    localparam int FixedRows    = 12;
    localparam int ReadyTimeout = 200;
    localparam int ResetTimeout = 64;
    localparam int MaxGap       = 3;

    // one pixel of stimulus
    typedef struct packed {
        binIdxT peakBin;
        countT  peakCount;
        // count of every other bin
        countT  bgCount;
        // second bin with the same peak count
        logic   secondOn;
        binIdxT secondBin;
        // random idle cycles between strobes
        logic   gapped;
    } stimRowT;

    logic     clk;
    logic     rstN;
    logic     binValid;
    countT    binCount;
    pixelIdxT rdAddr;
    logic     algebraicReady;
    pixelIdxT thPixel;
    thRecordT rdData;

    stimRowT  stimTable [Rows];
    // cycle of each pixel's last bin strobe
    int       lastCycle [Rows];
    thRecordT latest [`PIXEL_NUM_PER_RAM];
    int       cycleCnt = 0;

    clockGen clockGen_i (
        .clk  (clk),
        .rstN (rstN)
    );

    siFhTop siFhTop_i (
        .clk            (clk),
        .rstN           (rstN),
        .binValid       (binValid),
        .binCount       (binCount),
        .rdAddr         (rdAddr),
        .algebraicReady (algebraicReady),
        .thPixel        (thPixel),
        .rdData         (rdData)
    );

    bind siFhTop siFhTop_assert siFhTop_assert_i (
        .clk            (clk),
        .rstN           (rstN),
        .peakDone       (peakDone),
        .algebraicReady (algebraicReady),
        .thRecord       (thRecord)
    );

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    task automatic abortRun();
        $display("TEST FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic checkRecord(string name, thRecordT got, thRecordT exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkPixel(string name, pixelIdxT got, pixelIdxT exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkLatency(int got, int exp);
        if (got != exp) begin
            $display("error: algebraicReady latency got %h expected %h", got, exp);
            abortRun();
        end
    endtask

    // count of one bin as the table describes it
    function automatic countT binValue(stimRowT row, int bin);
        countT v;
        v = row.bgCount;
        if (bin == int'(row.peakBin)) begin
            v = row.peakCount;
        end
        if (row.secondOn && bin == int'(row.secondBin)) begin
            v = row.peakCount;
        end
        return v;
    endfunction

    // expected record from the lowest of the highest bins and its window
    function automatic thRecordT expectRecord(stimRowT row);
        thRecordT rec;
        int b;
        int bestBin;
        int bestCount;
        int sb;
        int levelMax;
        int ch;
        int lo;
        int hi;
        bestBin   = 0;
        bestCount = int'(binValue(row, 0));
        for (b = 1; b < `BIN_NUM; b++) begin
            if (int'(binValue(row, b)) > bestCount) begin
                bestBin   = b;
                bestCount = int'(binValue(row, b));
            end
        end
        // one bin width in level units
        sb       = 1 << (`NP - `NB);
        levelMax = (1 << `NP) - 1;
        ch       = bestBin * sb;
        if (ch < sb) begin
            lo = 0;
            hi = 2 * sb;
        end else if (ch > levelMax - sb) begin
            lo = levelMax - 2 * sb;
            hi = levelMax;
        end else begin
            lo = ch - sb;
            hi = ch + sb;
        end
        rec.thMinus    = levelT'(lo);
        rec.thPositive = levelT'(hi);
        rec.peakCount  = countT'(bestCount);
        rec.peakValid  = (bestCount >= `MIN_PEAK_COUNT);
        return rec;
    endfunction

    task automatic loadTable();
        int k;
        // mid-range, both clamps, ties, noise floor edges
        stimTable[0]  = '{4'd7, 12'd200, 12'd3, 1'b0, 4'd0, 1'b0};
        stimTable[1]  = '{4'd0, 12'd50, 12'd2, 1'b0, 4'd0, 1'b0};
        stimTable[2]  = '{4'd15, 12'd60, 12'd1, 1'b0, 4'd0, 1'b0};
        stimTable[3]  = '{4'd9, 12'd77, 12'd5, 1'b1, 4'd4, 1'b1};
        stimTable[4]  = '{4'd5, 12'd6, 12'd1, 1'b0, 4'd0, 1'b1};
        stimTable[5]  = '{4'd1, 12'd90, 12'd4, 1'b0, 4'd0, 1'b0};
        stimTable[6]  = '{4'd14, 12'd90, 12'd4, 1'b0, 4'd0, 1'b0};
        stimTable[7]  = '{4'd12, 12'd100, 12'd0, 1'b1, 4'd13, 1'b1};
        stimTable[8]  = '{4'd3, 12'd8, 12'd7, 1'b0, 4'd0, 1'b0};
        stimTable[9]  = '{4'd10, 12'd7, 12'd0, 1'b0, 4'd0, 1'b0};
        // flat histogram where every bin ties so bin 0 wins
        stimTable[10] = '{4'd6, 12'd20, 12'd20, 1'b0, 4'd0, 1'b0};
        stimTable[11] = '{4'd11, 12'd4095, 12'd4094, 1'b1, 4'd2, 1'b1};
        for (k = FixedRows; k < Rows; k++) begin
            stimTable[k].peakBin   = binIdxT'($urandom_range(`BIN_NUM - 1));
            stimTable[k].peakCount = countT'($urandom_range((1 << `COUNT_W) - 1));
            stimTable[k].bgCount   = countT'($urandom_range(63));
            stimTable[k].secondOn  = ($urandom_range(1) == 1);
            stimTable[k].secondBin = binIdxT'($urandom_range(`BIN_NUM - 1));
            stimTable[k].gapped    = ($urandom_range(1) == 1);
        end
    endtask

    task automatic waitReset();
        int waited;
        waited = 0;
        while (rstN !== 1'b1) begin
            if (waited >= ResetTimeout) begin
                $display("reset was never released");
                abortRun();
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // address in one cycle and data valid the cycle after
    task automatic readRecord(pixelIdxT addr, output thRecordT rec);
        @(posedge clk);
        rdAddr <= addr;
        @(posedge clk);
        @(negedge clk);
        rec = rdData;
    endtask

    task automatic driveRow(int k);
        int b;
        int gap;
        for (b = 0; b < `BIN_NUM; b++) begin
            @(posedge clk);
            binValid <= 1'b1;
            binCount <= binValue(stimTable[k], b);
            if (b == `BIN_NUM - 1) begin
                // note the strobe cycle of the last bin
                @(negedge clk);
                lastCycle[k] = cycleCnt;
            end else if (stimTable[k].gapped) begin
                gap = int'($urandom_range(MaxGap));
                repeat (gap) begin
                    @(posedge clk);
                    binValid <= 1'b0;
                end
            end
        end
    endtask

    // completion strobe timing, pixel index and stored record per row
    task automatic watchResults();
        int k;
        int waited;
        thRecordT rec;
        for (k = 0; k < Rows; k++) begin
            waited = 0;
            @(negedge clk);
            while (!algebraicReady) begin
                if (waited >= ReadyTimeout) begin
                    $display("no algebraicReady for row %0d within %0d cycles", k, ReadyTimeout);
                    abortRun();
                end
                waited++;
                @(negedge clk);
            end
            checkLatency(cycleCnt - lastCycle[k], 2);
            checkPixel("thPixel", thPixel, pixelIdxT'(k % `PIXEL_NUM_PER_RAM));
            readRecord(thPixel, rec);
            checkRecord($sformatf("rdData[%0d]", k % `PIXEL_NUM_PER_RAM), rec,
                        expectRecord(stimTable[k]));
        end
    endtask

    initial begin
        int k;
        int a;
        thRecordT rec;
        binValid = 1'b0;
        binCount = '0;
        rdAddr   = '0;
        void'($urandom(32'h45b8_b5e4));
        loadTable();
        waitReset();

        // store is empty after reset
        for (a = 0; a < `PIXEL_NUM_PER_RAM; a++) begin
            readRecord(pixelIdxT'(a), rec);
            checkRecord($sformatf("rdData[%0d]", a), rec, '0);
        end

        // pixels back to back with results checked as they come
        fork
            begin
                for (k = 0; k < Rows; k++) begin
                    driveRow(k);
                end
                @(posedge clk);
                binValid <= 1'b0;
            end
            watchResults();
        join

        // last two rows wrapped onto pixels 0 and 1
        for (k = 0; k < Rows; k++) begin
            latest[k % `PIXEL_NUM_PER_RAM] = expectRecord(stimTable[k]);
        end
        for (a = 0; a < `PIXEL_NUM_PER_RAM; a++) begin
            readRecord(pixelIdxT'(a), rec);
            checkRecord($sformatf("rdData[%0d]", a), rec, latest[a]);
        end

        if (siFhTop_i.siFhTop_assert_i.failCount != 0) begin
            $display("assertions failed during the run");
            abortRun();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+hw
hw/siFhPkg.sv
hw/peakFinder.sv
hw/algebraicBlock.sv
hw/thresholdRam.sv
hw/siFhTop.sv
tb/clockGen.sv
tb/siFhTop_assert.sv
tb/siFhTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the siFh testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module siFhTb \
    -Mdir obj_dir \
    -o siFhTb

# The simulator exits non-zero on $fatal; the log decides the result.
./obj_dir/siFhTb > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
